//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_microstepper
FILELIST  = compile.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- compile.f
design/stepper_pkg.sv
design/chopper_pkg.sv
design/step_sync.sv
design/microstep_decoder.sv
design/cosine_table.sv
design/current_dac.sv
design/chopper.sv
design/charge_pump.sv
design/microstepper_top.sv
sim/stepper_checker.sv
sim/tb_microstepper.sv

//--- design/charge_pump.sv
module charge_pump #(
  parameter int CP_DIV = 8
) (
  input  logic clk,
  input  logic resetn,
  output logic chargepump_pin
);

  localparam int CNT_W = $clog2(CP_DIV + 1);

  logic [CNT_W-1:0] div_cnt;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      div_cnt        <= '0;
      chargepump_pin <= 1'b0;
    end else if (div_cnt == CNT_W'(CP_DIV - 1)) begin
      div_cnt        <= '0;
      chargepump_pin <= ~chargepump_pin;  // Half period done
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

endmodule

//--- design/chopper.sv
module chopper #(
  parameter int OFF_TIME   = 810,
  parameter int FAST_TIME  = 304,
  parameter int BLANK_TIME = 40
) (
  input  logic       clk,
  input  logic       resetn,
  input  logic       enable_s,
  input  logic       cmp_s,
  input  logic       pol,
  output logic [1:0] sw_h,
  output logic [1:0] sw_l
);

  localparam chopper_pkg::chop_time_t BLANK_LOAD = chopper_pkg::chop_time_t'(BLANK_TIME - 1);
  localparam chopper_pkg::chop_time_t OFF_LOAD   = chopper_pkg::chop_time_t'(OFF_TIME - 1);
  localparam chopper_pkg::chop_time_t SLOW_AT    =
    chopper_pkg::chop_time_t'(OFF_TIME - FAST_TIME);

  chopper_pkg::chopper_state_t state;
  chopper_pkg::chop_time_t     blank_timer;
  chopper_pkg::chop_time_t     off_timer;
  logic                        pol_d;

  always_ff @(posedge clk) begin
    if (!resetn || !enable_s) begin
      state       <= chopper_pkg::BLANK;
      blank_timer <= BLANK_LOAD;
      off_timer   <= '0;
      pol_d       <= pol;
    end else if (pol != pol_d) begin  // Current direction flips, restart blanking
      state       <= chopper_pkg::BLANK;
      blank_timer <= BLANK_LOAD;
      pol_d       <= pol;
    end else begin
      case (state)
        chopper_pkg::BLANK: begin
          if (blank_timer == '0) begin
            state <= chopper_pkg::DRIVE;
          end else begin
            blank_timer <= blank_timer - 1'b1;
          end
        end
        chopper_pkg::DRIVE: begin
          if (cmp_s) begin  // Peak current reached
            state     <= chopper_pkg::FAST_DECAY;
            off_timer <= OFF_LOAD;
          end
        end
        chopper_pkg::FAST_DECAY: begin
          off_timer <= off_timer - 1'b1;
          if (off_timer == SLOW_AT) begin
            state <= chopper_pkg::SLOW_DECAY;
          end
        end
        default: begin
          if (off_timer == '0) begin
            state       <= chopper_pkg::BLANK;
            blank_timer <= BLANK_LOAD;
          end else begin
            off_timer <= off_timer - 1'b1;
          end
        end
      endcase
    end
  end

  // Bit 0 is leg 1, bit 1 is leg 2
  always_comb begin
    sw_h = 2'b00;
    sw_l = 2'b00;
    if (enable_s) begin
      case (state)
        chopper_pkg::BLANK,
        chopper_pkg::DRIVE: begin
          sw_h = {~pol, pol};
          sw_l = {pol, ~pol};
        end
        chopper_pkg::FAST_DECAY: begin
          sw_h = {pol, ~pol};
          sw_l = {~pol, pol};
        end
        default: sw_l = 2'b11;  // Recirculate through the low sides
      endcase
    end
  end

  no_shoot_through: assert property (@(posedge clk) disable iff (!resetn)
    (sw_h & sw_l) == 2'b00);

endmodule

//--- design/chopper_pkg.sv
package chopper_pkg;

  localparam int TIME_W = 10;  // Holds the longest off time

  typedef logic [TIME_W-1:0] chop_time_t;

  typedef enum logic [1:0] {
    BLANK,       // Bridge driven, comparator ignored
    DRIVE,       // Bridge driven, waiting for peak current
    FAST_DECAY,  // Bridge reversed
    SLOW_DECAY   // Both low sides on
  } chopper_state_t;

endpackage

//--- design/cosine_table.sv
module cosine_table (
  input  logic                        clk,
  input  stepper_pkg::cos_index_t     index,
  output stepper_pkg::current_level_t level
);

  stepper_pkg::current_level_t value;

  // 255 * cos(i * pi / 128)
  always_comb begin
    case (index)
      6'd0:  value = 8'd255;
      6'd1:  value = 8'd255;
      6'd2:  value = 8'd255;
      6'd3:  value = 8'd254;
      6'd4:  value = 8'd254;
      6'd5:  value = 8'd253;
      6'd6:  value = 8'd252;
      6'd7:  value = 8'd251;
      6'd8:  value = 8'd250;
      6'd9:  value = 8'd249;
      6'd10: value = 8'd247;
      6'd11: value = 8'd246;
      6'd12: value = 8'd244;
      6'd13: value = 8'd242;
      6'd14: value = 8'd240;
      6'd15: value = 8'd238;
      6'd16: value = 8'd236;
      6'd17: value = 8'd233;
      6'd18: value = 8'd231;
      6'd19: value = 8'd228;
      6'd20: value = 8'd225;
      6'd21: value = 8'd222;
      6'd22: value = 8'd219;
      6'd23: value = 8'd215;
      6'd24: value = 8'd212;
      6'd25: value = 8'd208;
      6'd26: value = 8'd205;
      6'd27: value = 8'd201;
      6'd28: value = 8'd197;
      6'd29: value = 8'd193;
      6'd30: value = 8'd189;
      6'd31: value = 8'd185;
      6'd32: value = 8'd180;  // 45 degrees
      6'd33: value = 8'd176;
      6'd34: value = 8'd171;
      6'd35: value = 8'd167;
      6'd36: value = 8'd162;
      6'd37: value = 8'd157;
      6'd38: value = 8'd152;
      6'd39: value = 8'd147;
      6'd40: value = 8'd142;
      6'd41: value = 8'd136;
      6'd42: value = 8'd131;
      6'd43: value = 8'd126;
      6'd44: value = 8'd120;
      6'd45: value = 8'd115;
      6'd46: value = 8'd109;
      6'd47: value = 8'd103;
      6'd48: value = 8'd98;
      6'd49: value = 8'd92;
      6'd50: value = 8'd86;
      6'd51: value = 8'd80;
      6'd52: value = 8'd74;
      6'd53: value = 8'd68;
      6'd54: value = 8'd62;
      6'd55: value = 8'd56;
      6'd56: value = 8'd50;
      6'd57: value = 8'd44;
      6'd58: value = 8'd37;
      6'd59: value = 8'd31;
      6'd60: value = 8'd25;
      6'd61: value = 8'd19;
      6'd62: value = 8'd13;
      default: value = 8'd6;  // Entry 63
    endcase
  end

  always_ff @(posedge clk) begin
    level <= value;
  end

endmodule

//--- design/current_dac.sv
module current_dac (
  input  logic                        clk,
  input  logic                        resetn,
  input  logic                        enable_s,
  input  stepper_pkg::current_level_t level,
  output logic                        analog_out
);

  stepper_pkg::current_level_t acc;
  logic [8:0]                  sum;

  assign sum = {1'b0, acc} + {1'b0, level};

  // Carry density equals level / 256
  always_ff @(posedge clk) begin
    if (!resetn || !enable_s) begin
      acc        <= '0;
      analog_out <= 1'b0;
    end else begin
      acc        <= sum[7:0];
      analog_out <= sum[8];
    end
  end

endmodule

//--- design/microstep_decoder.sv
module microstep_decoder (
  input  logic                      clk,
  input  logic                      resetn,
  input  stepper_pkg::phase_count_t phase,
  output stepper_pkg::cos_index_t   index_a,
  output stepper_pkg::cos_index_t   index_b,
  output logic                      pol_a,
  output logic                      pol_b
);

  logic [1:0]              quad;
  stepper_pkg::cos_index_t idx;
  logic                    pol_a_q;
  logic                    pol_b_q;

  assign quad = phase[7:6];
  assign idx  = phase[5:0];

  // Inverting a 6-bit index gives 63 - i
  always_ff @(posedge clk) begin
    index_a <= quad[0] ? ~idx : idx;
    index_b <= quad[0] ? idx : ~idx;
  end

  // Second stage lines the polarity up with the table output
  always_ff @(posedge clk) begin
    if (!resetn) begin
      pol_a_q <= 1'b1;  // Polarity of phase 0
      pol_b_q <= 1'b1;
      pol_a   <= 1'b1;
      pol_b   <= 1'b1;
    end else begin
      pol_a_q <= (quad == 2'd0) || (quad == 2'd3);
      pol_b_q <= ~quad[1];
      pol_a   <= pol_a_q;
      pol_b   <= pol_b_q;
    end
  end

endmodule

//--- design/microstepper_top.sv
module microstepper_top #(
  parameter int OFF_TIME   = 810,
  parameter int FAST_TIME  = 304,
  parameter int BLANK_TIME = 40,
  parameter int CP_DIV     = 8
) (
  input  logic       clk,
  input  logic       resetn,
  input  logic       step,
  input  logic       dir,
  input  logic       enable,
  input  logic       analog_cmp1,
  input  logic       analog_cmp2,
  output logic [3:0] s_h,
  output logic [3:0] s_l,
  output logic       analog_out1,
  output logic       analog_out2,
  output logic       chargepump_pin
);

  stepper_pkg::phase_count_t   phase;
  stepper_pkg::cos_index_t     index_a;
  stepper_pkg::cos_index_t     index_b;
  stepper_pkg::current_level_t level_a;
  stepper_pkg::current_level_t level_b;
  logic                        pol_a;
  logic                        pol_b;
  logic                        enable_s;
  logic                        cmp_a_s;
  logic                        cmp_b_s;

  step_sync u_step_sync (
    .clk         (clk),
    .resetn      (resetn),
    .step        (step),
    .dir         (dir),
    .enable      (enable),
    .analog_cmp1 (analog_cmp1),
    .analog_cmp2 (analog_cmp2),
    .phase       (phase),
    .enable_s    (enable_s),
    .cmp_a_s     (cmp_a_s),
    .cmp_b_s     (cmp_b_s)
  );

  microstep_decoder u_decoder (
    .clk     (clk),
    .resetn  (resetn),
    .phase   (phase),
    .index_a (index_a),
    .index_b (index_b),
    .pol_a   (pol_a),
    .pol_b   (pol_b)
  );

  cosine_table u_table_a (.clk(clk), .index(index_a), .level(level_a));
  cosine_table u_table_b (.clk(clk), .index(index_b), .level(level_b));

  current_dac u_dac_a (
    .clk        (clk),
    .resetn     (resetn),
    .enable_s   (enable_s),
    .level      (level_a),
    .analog_out (analog_out1)
  );

  current_dac u_dac_b (
    .clk        (clk),
    .resetn     (resetn),
    .enable_s   (enable_s),
    .level      (level_b),
    .analog_out (analog_out2)
  );

  // Coil A on bits 1:0, coil B on bits 3:2
  chopper #(
    .OFF_TIME   (OFF_TIME),
    .FAST_TIME  (FAST_TIME),
    .BLANK_TIME (BLANK_TIME)
  ) u_chopper_a (
    .clk      (clk),
    .resetn   (resetn),
    .enable_s (enable_s),
    .cmp_s    (cmp_a_s),
    .pol      (pol_a),
    .sw_h     (s_h[1:0]),
    .sw_l     (s_l[1:0])
  );

  chopper #(
    .OFF_TIME   (OFF_TIME),
    .FAST_TIME  (FAST_TIME),
    .BLANK_TIME (BLANK_TIME)
  ) u_chopper_b (
    .clk      (clk),
    .resetn   (resetn),
    .enable_s (enable_s),
    .cmp_s    (cmp_b_s),
    .pol      (pol_b),
    .sw_h     (s_h[3:2]),
    .sw_l     (s_l[3:2])
  );

  charge_pump #(
    .CP_DIV (CP_DIV)
  ) u_charge_pump (
    .clk            (clk),
    .resetn         (resetn),
    .chargepump_pin (chargepump_pin)
  );

endmodule

//--- design/step_sync.sv
module step_sync (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      step,
  input  logic                      dir,
  input  logic                      enable,
  input  logic                      analog_cmp1,
  input  logic                      analog_cmp2,
  output stepper_pkg::phase_count_t phase,
  output logic                      enable_s,
  output logic                      cmp_a_s,
  output logic                      cmp_b_s
);

  logic [2:0] step_ff;  // Bit 2 is the previous synchronized value
  logic [1:0] dir_ff;
  logic [1:0] enable_ff;
  logic [1:0] cmp_a_ff;
  logic [1:0] cmp_b_ff;
  logic       step_rise;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      step_ff   <= '0;
      dir_ff    <= '0;
      enable_ff <= '0;
      cmp_a_ff  <= '0;
      cmp_b_ff  <= '0;
    end else begin
      step_ff   <= {step_ff[1:0], step};
      dir_ff    <= {dir_ff[0], dir};
      enable_ff <= {enable_ff[0], enable};
      cmp_a_ff  <= {cmp_a_ff[0], analog_cmp1};
      cmp_b_ff  <= {cmp_b_ff[0], analog_cmp2};
    end
  end

  assign step_rise = step_ff[1] & ~step_ff[2];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      phase <= '0;
    end else if (step_rise) begin
      phase <= dir_ff[1] ? phase + 1'b1 : phase - 1'b1;  // Wraps modulo 256
    end
  end

  assign enable_s = enable_ff[1];
  assign cmp_a_s  = cmp_a_ff[1];
  assign cmp_b_s  = cmp_b_ff[1];

  // A one-cycle step pulse could be lost by the synchronizer
  step_min_high: assert property (@(posedge clk) disable iff (!resetn)
    step_rise |=> step_ff[1]);

endmodule

//--- design/stepper_pkg.sv
package stepper_pkg;

  localparam int PHASE_W = 8;  // 256 microsteps per electrical turn
  localparam int COS_W   = 6;  // Quarter wave of 64 entries
  localparam int LEVEL_W = 8;

  // Bits 7:6 quadrant, bits 5:0 index within the quadrant
  typedef logic [PHASE_W-1:0] phase_count_t;

  typedef logic [COS_W-1:0] cos_index_t;

  // 255 is full scale coil current
  typedef logic [LEVEL_W-1:0] current_level_t;

endpackage

//--- sim/stepper_checker.sv
module stepper_checker #(
  parameter int OFF_TIME   = 810,
  parameter int FAST_TIME  = 304,
  parameter int BLANK_TIME = 40,
  parameter int CP_DIV     = 8
) (
  input logic       clk,
  input logic       resetn,
  input logic       step,
  input logic       dir,
  input logic       enable,
  input logic       analog_cmp1,
  input logic       analog_cmp2,
  input logic [3:0] s_h,
  input logic [3:0] s_l,
  input logic       analog_out1,
  input logic       analog_out2,
  input logic       chargepump_pin
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [2:0] step_ff;
  logic [1:0] dir_ff;
  logic [1:0] en_ff;
  logic [1:0] cmpa_ff;
  logic [1:0] cmpb_ff;
  logic [7:0] m_phase;
  logic [7:0] ph_d1;
  logic [7:0] ph_d2;  // Phase seen by levels and polarities
  logic [8:0] acc [2];
  chopper_pkg::chopper_state_t cst [2];
  int         cn [2];
  logic       cpol [2];
  int         cp_cnt;
  logic       cp_pin;
  logic       armed = 1'b0;
  int         err_count = 0;
  int         test_err_start = 0;
  int         pass_cnt = 0;
  int         fail_cnt = 0;

  function automatic int coil_level(logic [7:0] ph, int coil);
    int idx;
    idx = ph[5:0];
    if (ph[6] ^ coil[0]) idx = 63 - idx;  // Coil B runs a quarter turn behind
    return int'($floor(255.0 * $cos(idx * 3.14159265358979 / 128.0) + 0.5));
  endfunction

  function automatic logic coil_pol(logic [7:0] ph, int coil);
    if (coil == 0) return (ph[7:6] == 2'd0) || (ph[7:6] == 2'd3);
    return !ph[7];
  endfunction

  // Returns {h leg2, h leg1, l leg2, l leg1}
  function automatic logic [3:0] exp_sw(chopper_pkg::chopper_state_t st, logic p, logic en);
    if (!en) return 4'b0000;
    case (st)
      chopper_pkg::BLANK, chopper_pkg::DRIVE: return {~p, p, p, ~p};
      chopper_pkg::FAST_DECAY: return {p, ~p, ~p, p};
      default: return 4'b0011;
    endcase
  endfunction

  task automatic compare(string name, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      err_count++;
      $display("ERR t=%0t %s exp=%0h act=%0h", $time, name, exp, act);
    end
  endtask

  always @(posedge clk) begin : model
    logic pol_c;
    logic cmp_c;
    armed <= 1'b1;
    if (!resetn) begin
      {step_ff, dir_ff, en_ff, cmpa_ff, cmpb_ff} <= '0;
      {m_phase, ph_d1, ph_d2} <= '0;
      cp_cnt <= 0;
      cp_pin <= 1'b0;
    end else begin
      step_ff <= {step_ff[1:0], step};
      dir_ff  <= {dir_ff[0], dir};
      en_ff   <= {en_ff[0], enable};
      cmpa_ff <= {cmpa_ff[0], analog_cmp1};
      cmpb_ff <= {cmpb_ff[0], analog_cmp2};
      if (step_ff[1] && !step_ff[2]) m_phase <= dir_ff[1] ? m_phase + 8'd1 : m_phase - 8'd1;
      ph_d1 <= m_phase;
      ph_d2 <= ph_d1;
      cp_cnt <= (cp_cnt == CP_DIV - 1) ? 0 : cp_cnt + 1;
      if (cp_cnt == CP_DIV - 1) cp_pin <= ~cp_pin;
    end
    for (int c = 0; c < 2; c++) begin
      pol_c = coil_pol(ph_d2, c);
      cmp_c = (c == 0) ? cmpa_ff[1] : cmpb_ff[1];
      if (!resetn || !en_ff[1]) acc[c] <= '0;
      else acc[c] <= {1'b0, acc[c][7:0]} + 9'(coil_level(ph_d2, c));  // Bit 8 is the DAC bit
      if (!resetn || !en_ff[1] || pol_c != cpol[c]) begin
        cst[c]  <= chopper_pkg::BLANK;
        cn[c]   <= 0;
        cpol[c] <= pol_c;
      end else begin
        cn[c] <= cn[c] + 1;
        case (cst[c])
          chopper_pkg::BLANK: if (cn[c] == BLANK_TIME - 1) begin
            cst[c] <= chopper_pkg::DRIVE;
            cn[c]  <= 0;
          end
          chopper_pkg::DRIVE: if (cmp_c) begin
            cst[c] <= chopper_pkg::FAST_DECAY;
            cn[c]  <= 0;
          end
          chopper_pkg::FAST_DECAY: if (cn[c] == FAST_TIME - 1) begin
            cst[c] <= chopper_pkg::SLOW_DECAY;
            cn[c]  <= 0;
          end
          default: if (cn[c] == OFF_TIME - FAST_TIME - 1) begin
            cst[c] <= chopper_pkg::BLANK;
            cn[c]  <= 0;
          end
        endcase
      end
    end
  end

  always @(negedge clk) begin : check
    logic [3:0] ea;
    logic [3:0] eb;
    if (armed) begin
      ea = exp_sw(cst[0], coil_pol(ph_d2, 0), en_ff[1]);
      eb = exp_sw(cst[1], coil_pol(ph_d2, 1), en_ff[1]);
      compare("s_h", {eb[3:2], ea[3:2]}, s_h);
      compare("s_l", {eb[1:0], ea[1:0]}, s_l);
      compare("analog_out1", acc[0][8], analog_out1);
      compare("analog_out2", acc[1][8], analog_out2);
      compare("chargepump_pin", cp_pin, chargepump_pin);
      if ((s_h & s_l) != 4'b0000) begin
        err_count++;
        $display("High and low switch of one leg on together at %0t", $time);
      end
    end
  end

  // Counts DAC ones over a full 256-cycle window
  task automatic check_window();
    int ones_a;
    int ones_b;
    int exp_a;
    int exp_b;
    ones_a = 0;
    ones_b = 0;
    exp_a  = coil_level(ph_d2, 0);
    exp_b  = coil_level(ph_d2, 1);
    repeat (256) begin
      @(negedge clk);
      ones_a += int'(analog_out1);
      ones_b += int'(analog_out2);
    end
    compare("analog_out1 ones", exp_a, ones_a);
    compare("analog_out2 ones", exp_b, ones_b);
  endtask

  task automatic end_test(string name);
    if (err_count == test_err_start) begin
      pass_cnt++;
      $display("test %s: ok", name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d errors", name, err_count - test_err_start);
    end
    test_err_start = err_count;
  endtask

endmodule

//--- sim/tb_microstepper.sv
module tb_microstepper;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int OFF_TIME   = 810;
  localparam int FAST_TIME  = 304;
  localparam int BLANK_TIME = 40;
  localparam int CP_DIV     = 8;
  localparam int STEP_MAX   = 9;  // Longest step_once in cycles
  localparam int TEST_CYCLES = 43 + (BLANK_TIME + 20 + 20 * STEP_MAX)
    + 4 * (256 * STEP_MAX + 264) + (2 * BLANK_TIME + OFF_TIME + 40)
    + 4 * (64 * STEP_MAX + OFF_TIME + BLANK_TIME + 30) + 25;
  localparam int LIMIT_CYCLES = TEST_CYCLES * 12 / 10;

  logic        clk;
  logic        resetn;
  logic        step;
  logic        dir;
  logic        enable;
  logic        analog_cmp1;
  logic        analog_cmp2;
  logic [3:0]  s_h;
  logic [3:0]  s_l;
  logic        analog_out1;
  logic        analog_out2;
  logic        chargepump_pin;
  int unsigned seed = 60814;

  always #50 clk = ~clk;

  function automatic int unsigned rnd(int unsigned range);
    seed = seed * 32'd1103515245 + 32'd12345;
    return (seed >> 16) % range;
  endfunction

  task automatic cycles(int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic step_once(logic d);
    dir  <= d;
    step <= 1'b1;
    cycles(2 + int'(rnd(3)));
    step <= 1'b0;
    cycles(2 + int'(rnd(4)));
  endtask

  task automatic pulse_cmp();
    analog_cmp1 <= 1'b1;
    analog_cmp2 <= 1'b1;
    cycles(2);
    analog_cmp1 <= 1'b0;
    analog_cmp2 <= 1'b0;
  endtask

  microstepper_top #(.OFF_TIME(OFF_TIME), .FAST_TIME(FAST_TIME),
    .BLANK_TIME(BLANK_TIME), .CP_DIV(CP_DIV)) DUT (.*);

  stepper_checker #(.OFF_TIME(OFF_TIME), .FAST_TIME(FAST_TIME),
    .BLANK_TIME(BLANK_TIME), .CP_DIV(CP_DIV)) chk (.*);

  initial begin
    logic [7:0] target;
    clk = 1'b0;
    resetn = 1'b0;
    {step, dir, enable, analog_cmp1, analog_cmp2} = '0;
    cycles(3);
    resetn <= 1'b1;
    cycles(40);
    chk.end_test("reset_enable_low");
    enable <= 1'b1;
    cycles(BLANK_TIME + 10);
    repeat (20) step_once(1'(rnd(2)));
    cycles(10);
    chk.end_test("step_bursts");
    for (int q = 0; q < 4; q++) begin
      target = {2'(q), 6'(rnd(64))};
      while (chk.m_phase != target) step_once(1'b1);
      cycles(8);  // Level pipeline settles
      chk.check_window();
      @(posedge clk);
    end
    chk.end_test("dac_windows");
    cycles(BLANK_TIME + 10);
    pulse_cmp();
    cycles(4);
    pulse_cmp();  // Lands in fast decay
    cycles(OFF_TIME + 2);
    pulse_cmp();  // Lands in blanking
    cycles(BLANK_TIME + 20);
    chk.end_test("chop_cycle");
    repeat (4) begin
      while (chk.m_phase[5:0] != 6'd63) step_once(1'b1);
      dir  <= 1'b1;
      step <= 1'b1;
      cycles(3);
      step <= 1'b0;
      cycles(4);
      pulse_cmp();
      cycles(OFF_TIME + BLANK_TIME + 20);
    end
    chk.end_test("pol_restart_blank");
    enable <= 1'b0;
    cycles(20);
    chk.end_test("enable_off");
    $display("tests passed %0d failed %0d", chk.pass_cnt, chk.fail_cnt);
    if (chk.fail_cnt == 0 && chk.err_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(LIMIT_CYCLES * 100);
    $display("Watchdog expired after %0d cycles, run did not finish", LIMIT_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
